// File: common/rdyq_geom_pkg.sv
// queue geometry of the ready lists, imported by the FIFO, bank, decode, mux and testbench
package rdyq_geom_pkg;

  // ========================================
  // queue geometry
  // ========================================
  localparam int NUM_QUEUES  = 5;             // one per priority level
  localparam int QUEUE_DEPTH = 256;           // handles per queue, power of two
  localparam int HANDLE_W    = 9;             // task handle bits

  // fill count must hold QUEUE_DEPTH itself, hence one bit more than the pointers
  localparam int COUNT_W = 9;                 // 0 to 256
  localparam int PTR_W   = 8;                 // read and write pointers, wrap naturally
  localparam int QIDX_W  = 3;                 // queue index from ad[3:1]

endpackage

// File: common/rdyq_map_pkg.sv
// bus register map of the ready-queue peripheral, imported by decode, read mux and testbench
package rdyq_map_pkg;

  // ========================================
  // bus widths
  // ========================================
  localparam int ADDR_W = 5;                  // ad[4:0]
  localparam int DATA_W = 8;                  // i[7:0] and o[7:0]

  // ========================================
  // address fields
  // ========================================
  localparam int BYTE_SEL_BIT = 0;            // ad[0] picks the byte
  localparam int QSEL_LSB     = 1;            // ad[3:1] is the queue index
  localparam int QSEL_MSB     = 3;
  localparam int REG_SEL_BIT  = 4;            // ad[4] picks head or count

  localparam logic BYTE_LO   = 1'b0;          // low byte, or the latch write
  localparam logic BYTE_HI   = 1'b1;          // high byte, or the push write
  localparam logic REG_HEAD  = 1'b0;          // head entry registers
  localparam logic REG_COUNT = 1'b1;          // fill count registers

  // ========================================
  // decoded accesses
  // ========================================
  // one value per bus cycle; op_none when the peripheral is not selected
  typedef enum logic [2:0] {
    op_none     = 3'd0,                       // idle or not selected
    op_latch    = 3'd1,                       // write low byte of a handle
    op_push     = 3'd2,                       // write bit 8 and push
    op_peek_hi  = 3'd3,                       // read head bit 8, no pop
    op_pop_lo   = 3'd4,                       // read head low byte and pop
    op_count_lo = 3'd5,                       // fill count bits 7:0
    op_count_hi = 3'd6,                       // fill count bit 8
    op_unmapped = 3'd7                        // bad index or push to count page
  } rdyq_op_e;

endpackage

// File: filelist.f
common/rdyq_geom_pkg.sv
common/rdyq_map_pkg.sv
source/rdyq_bus_decode.sv
ready_fifos/ready_fifo.sv
ready_fifos/ready_fifo_bank.sv
source/rdyq_read_mux.sv
ready_fifos/ready_fifos.sv
sim/ready_fifos_props.sv
sim/tb_ready_fifos.sv

// File: ready_fifos/ready_fifo.sv
// one first-word-fall-through queue of task handles with a fill count, used by the queue bank
`timescale 1ns/1ns

module ready_fifo (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               push,
  input  logic                               pop,
  input  logic [rdyq_geom_pkg::HANDLE_W-1:0] din,
  output logic [rdyq_geom_pkg::HANDLE_W-1:0] head,
  output logic                               not_empty,
  output logic [rdyq_geom_pkg::COUNT_W-1:0]  count
);
  import rdyq_geom_pkg::*;

  logic [HANDLE_W-1:0] mem [QUEUE_DEPTH];           // handle storage
  logic [PTR_W-1:0]    wr_ptr;                      // next free slot
  logic [PTR_W-1:0]    rd_ptr;                      // oldest entry
  logic                full;
  logic                do_push;
  logic                do_pop;

  assign full      = (count == COUNT_W'(QUEUE_DEPTH));
  assign not_empty = (count != '0);
  assign do_push   = push & ~full;                  // full queue drops it
  assign do_pop    = pop & not_empty;               // empty pop does nothing

  // ========================================
  // storage
  // ========================================
  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= din;
  end

  // ========================================
  // pointers and count
  // ========================================
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;                    // wraps at depth
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

  // head falls through with no read latency, zero when empty
  assign head = not_empty ? mem[rd_ptr] : '0;

endmodule

// File: ready_fifos/ready_fifo_bank.sv
// queue bank: handle low-byte latch and the five priority queues, executes pushes and pops
`timescale 1ns/1ns

module ready_fifo_bank (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               fire,
  input  rdyq_map_pkg::rdyq_op_e             op,
  input  logic [rdyq_geom_pkg::QIDX_W-1:0]   qidx,
  input  logic [rdyq_map_pkg::DATA_W-1:0]    wdata,
  output logic [rdyq_geom_pkg::HANDLE_W-1:0] head_data [rdyq_geom_pkg::NUM_QUEUES],
  output logic [rdyq_geom_pkg::NUM_QUEUES-1:0] head_valid,
  output logic [rdyq_geom_pkg::COUNT_W-1:0]  count [rdyq_geom_pkg::NUM_QUEUES]
);
  import rdyq_map_pkg::*;
  import rdyq_geom_pkg::*;

  logic [DATA_W-1:0]   lo_latch;                    // first half of a handle
  logic [HANDLE_W-1:0] handle;                      // assembled on the push write
  logic                push_any;
  logic                pop_any;

  // ========================================
  // low-byte latch
  // ========================================
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      lo_latch <= '0;
    else if (fire && op == op_latch)
      lo_latch <= wdata;
  end

  assign handle   = {wdata[0], lo_latch};           // bit 8 rides on the push write
  assign push_any = fire && (op == op_push);
  assign pop_any  = fire && (op == op_pop_lo);

  // ========================================
  // queues
  // ========================================
  // decode has already mapped indexes 5 to 7 away, so no range check here
  for (genvar q = 0; q < NUM_QUEUES; q++)
  begin : g_queue
    ready_fifo u_fifo (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (push_any && (qidx == QIDX_W'(q))),  // only the indexed queue
      .pop       (pop_any && (qidx == QIDX_W'(q))),
      .din       (handle),
      .head      (head_data[q]),
      .not_empty (head_valid[q]),
      .count     (count[q])
    );
  end

endmodule

// File: ready_fifos/ready_fifos.sv
// top level of the ready-queue peripheral, attaches decode, queue bank and read mux to the CPU bus
`timescale 1ns/1ns

module ready_fifos (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            cs,
  input  logic                            vda,
  input  logic                            rw,
  input  logic [rdyq_map_pkg::ADDR_W-1:0] ad,
  input  logic [rdyq_map_pkg::DATA_W-1:0] i,
  output logic                            rdy,
  output logic [rdyq_map_pkg::DATA_W-1:0] o
);
  import rdyq_map_pkg::*;
  import rdyq_geom_pkg::*;

  rdyq_op_e            op;                          // decoded access
  logic [QIDX_W-1:0]   qidx;
  logic                fire;                        // completing cycle
  logic [HANDLE_W-1:0] head_data [NUM_QUEUES];
  logic [NUM_QUEUES-1:0] head_valid;
  logic [COUNT_W-1:0]  count [NUM_QUEUES];

  rdyq_bus_decode u_decode (
    .clk   (clk),
    .rst_n (rst_n),
    .cs    (cs),
    .vda   (vda),
    .rw    (rw),
    .ad    (ad),
    .rdy   (rdy),
    .fire  (fire),
    .op    (op),
    .qidx  (qidx)
  );

  ready_fifo_bank u_bank (
    .clk        (clk),
    .rst_n      (rst_n),
    .fire       (fire),
    .op         (op),
    .qidx       (qidx),
    .wdata      (i),
    .head_data  (head_data),
    .head_valid (head_valid),
    .count      (count)
  );

  rdyq_read_mux u_mux (
    .op         (op),
    .qidx       (qidx),
    .head_data  (head_data),
    .head_valid (head_valid),
    .count      (count),
    .o          (o)
  );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it; the exit status is the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f filelist.f --top-module tb_ready_fifos \
  -Mdir obj_dir -o sim_ready_fifos \
  && ./obj_dir/sim_ready_fifos \
  && echo "simulation finished without errors" \
  || { echo "simulation reported a failure"; exit 1; }

// File: sim/ready_fifos_props.sv
// bound assertions for the ready-queue peripheral: read wait state, single fire and queue bounds
`timescale 1ns/1ns

module ready_fifos_props (
  input logic                              clk,
  input logic                              rst_n,
  input logic                              cs,
  input logic                              vda,
  input logic                              rw,
  input logic                              rdy,
  input logic                              fire,
  input logic [rdyq_geom_pkg::COUNT_W-1:0] count [rdyq_geom_pkg::NUM_QUEUES]
);
  import rdyq_geom_pkg::*;

  logic rd_sel;                                                // read access on the bus

  assign rd_sel = cs & vda & rw;

  // ========================================
  // bus timing
  // ========================================
  a_read_first_wait: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(rd_sel) |-> !rdy) else $error("read did not wait in its first cycle");

  a_read_one_wait: assert property (@(posedge clk) disable iff (!rst_n)
    (rd_sel && !rdy) |=> rdy) else $error("read waited more than one cycle");

  a_fire_single: assert property (@(posedge clk) disable iff (!rst_n)
    fire |=> !fire) else $error("fire high in two consecutive cycles");

  // ========================================
  // queue bounds
  // ========================================
  for (genvar q = 0; q < NUM_QUEUES; q++)
  begin : g_count
    a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
      count[q] <= COUNT_W'(QUEUE_DEPTH)) else $error("fill count above queue depth");
  end

endmodule

bind ready_fifos ready_fifos_props u_props (
  .clk   (clk),
  .rst_n (rst_n),
  .cs    (cs),
  .vda   (vda),
  .rw    (rw),
  .rdy   (rdy),
  .fire  (fire),
  .count (count)
);

// File: sim/tb_ready_fifos.sv
// testbench for the ready-queue peripheral: drives the CPU bus, models the five queues, compares reads
`timescale 1ns/1ns

module tb_ready_fifos;
  import rdyq_map_pkg::*;
  import rdyq_geom_pkg::*;

  localparam int N_RAND      = 40;                             // random pushes
  localparam int N_FILL      = QUEUE_DEPTH + 4;                // overfill, last four dropped
  localparam int N_ACCESSES  = 40 + 6 * N_RAND + 2 * N_FILL + 2 * QUEUE_DEPTH + 60;
  localparam int WATCHDOG_NS = N_ACCESSES * 8 * 4 + 2000;      // 8 cycles of 4 ns each

  logic              clk;
  logic              rst_n;
  logic              cs;
  logic              vda;
  logic              rw;
  logic [ADDR_W-1:0] ad;
  logic [DATA_W-1:0] i;
  logic              rdy;
  logic [DATA_W-1:0] o;

  // ========================================
  // reference model state
  // ========================================
  logic [HANDLE_W-1:0] ref_mem [NUM_QUEUES][QUEUE_DEPTH];
  int                  ref_rd  [NUM_QUEUES];                   // oldest slot
  int                  ref_cnt [NUM_QUEUES];                   // fill level
  logic [DATA_W-1:0]   ref_latch;                              // low byte of next handle
  int unsigned         lcg_state;
  logic [DATA_W-1:0]   rd_got;                                 // sampled o
  logic [DATA_W-1:0]   rd_exp;                                 // model prediction
  event                read_done;

  ready_fifos UUT (.clk(clk), .rst_n(rst_n), .cs(cs), .vda(vda), .rw(rw), .ad(ad), .i(i),
                   .rdy(rdy), .o(o));

  always #2 clk = ~clk;                                        // 4 ns period

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 8;                                     // low bits are weak
  endfunction

  // expected read byte for an address, from the model state before the access
  function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] addr);
    int                  q;
    logic [HANDLE_W-1:0] head;
    q = int'(addr[3:1]);
    if (q >= NUM_QUEUES)
      return '0;                                               // unmapped index
    if (addr[4])
      return addr[0] ? DATA_W'(ref_cnt[q] >> 8) : DATA_W'(ref_cnt[q] & 255);
    if (ref_cnt[q] == 0)
      return '0;                                               // empty head reads zero
    head = ref_mem[q][ref_rd[q]];
    return addr[0] ? {{(DATA_W-1){1'b0}}, head[HANDLE_W-1]} : head[DATA_W-1:0];
  endfunction

  task automatic model_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    int q;
    q = int'(addr[3:1]);
    if (q < NUM_QUEUES)
    begin
      if (!addr[0])
        ref_latch = data;                                      // latch on either page
      else if (!addr[4] && ref_cnt[q] < QUEUE_DEPTH)           // full queue drops it
      begin
        ref_mem[q][(ref_rd[q] + ref_cnt[q]) % QUEUE_DEPTH] = {data[0], ref_latch};
        ref_cnt[q]++;
      end
    end
  endtask

  task automatic model_pop(input int q);
    if (ref_cnt[q] > 0)                                        // empty pop changes nothing
    begin
      ref_rd[q] = (ref_rd[q] + 1) % QUEUE_DEPTH;
      ref_cnt[q]--;
    end
  endtask

  task automatic stop_on_value(input string name, input logic [7:0] got, input logic [7:0] exp);
    $display("FAIL at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    $display("** FAIL **");
    $fatal(1, "value mismatch");
  endtask

  task automatic stop_with(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "bus protocol error");
  endtask

  // ========================================
  // bus accesses
  // ========================================
  task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    @(negedge clk);
    cs  = 1'b1;
    vda = 1'b1;
    rw  = 1'b0;
    ad  = addr;
    i   = data;
    #1;                                                        // rdy settled, edge not yet
    assert (rdy == 1'b1) else stop_on_value("rdy", {7'b0, rdy}, 8'd1);
    @(negedge clk);
    cs  = 1'b0;                                                // idle gap
    vda = 1'b0;
    model_write(addr, data);
  endtask

  task automatic bus_read(input logic [ADDR_W-1:0] addr);
    int waits;
    waits = 0;
    @(negedge clk);
    cs     = 1'b1;
    vda    = 1'b1;
    rw     = 1'b1;
    ad     = addr;
    rd_exp = expected_read(addr);
    #1;
    assert (rdy == 1'b0) else stop_on_value("rdy", {7'b0, rdy}, 8'd0);
    do
    begin
      @(negedge clk);
      waits++;
    end
    while (!rdy && waits < 4);
    assert (rdy == 1'b1)
      else stop_with($sformatf("read of address %h got no rdy in %0d cycles", addr, waits));
    assert (waits == 1)
      else stop_with($sformatf("read of address %h waited %0d cycles, not one", addr, waits));
    rd_got = o;                                                // middle of the rdy cycle
    -> read_done;
    @(negedge clk);
    cs  = 1'b0;
    vda = 1'b0;
    if (int'(addr[3:1]) < NUM_QUEUES && !addr[4] && !addr[0])
      model_pop(int'(addr[3:1]));                              // low-byte head read pops
  endtask

  task automatic push_handle(input int q, input logic [HANDLE_W-1:0] h);
    logic [DATA_W-1:0] junk;
    junk = DATA_W'(lcg_next());
    bus_write({1'b0, 3'(q), 1'b0}, h[7:0]);
    bus_write({1'b0, 3'(q), 1'b1}, {junk[7:1], h[8]});         // only bit 0 is used
  endtask

  task automatic check_counts();
    for (int q = 0; q < NUM_QUEUES; q++)
    begin
      bus_read({1'b1, 3'(q), 1'b0});
      bus_read({1'b1, 3'(q), 1'b1});
    end
  endtask

  task automatic drain_queue(input int q);
    while (ref_cnt[q] > 0)
    begin
      bus_read({1'b0, 3'(q), 1'b1});                           // bit 8 first, no pop
      bus_read({1'b0, 3'(q), 1'b0});
    end
  endtask

  // compare each sampled read with the model
  always @(read_done)
  begin
    assert (rd_got == rd_exp) else stop_on_value("o", rd_got, rd_exp);
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests finished");
    $display("** FAIL **");
    $fatal(1, "timeout");
  end

  // ========================================
  // test sequence
  // ========================================
  initial
  begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    cs        = 1'b0;
    vda       = 1'b0;
    rw        = 1'b0;
    ad        = '0;
    i         = '0;
    lcg_state = 78;
    ref_latch = '0;
    for (int q = 0; q < NUM_QUEUES; q++)
    begin
      ref_rd[q]  = 0;
      ref_cnt[q] = 0;
    end
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    for (int a = 0; a < 2 * NUM_QUEUES; a++)                   // reset state, all registers
    begin
      bus_read(ADDR_W'(16 + a));
      bus_read(ADDR_W'(a));
    end

    repeat (N_RAND) push_handle(int'(lcg_next() % NUM_QUEUES), HANDLE_W'(lcg_next()));
    check_counts();
    for (int q = 0; q < NUM_QUEUES; q++)
      drain_queue(q);
    check_counts();

    repeat (N_FILL) push_handle(2, HANDLE_W'(lcg_next()));     // count ends at 256
    check_counts();
    drain_queue(2);
    check_counts();

    bus_read({1'b0, 3'd3, 1'b1});                              // empty queue pop
    bus_read({1'b0, 3'd3, 1'b0});
    for (int q = NUM_QUEUES; q < 8; q++)
    begin
      push_handle(q, HANDLE_W'(lcg_next()));
      for (int b = 0; b < 4; b++)
        bus_read({b[1], 3'(q), b[0]});
    end
    bus_write({1'b1, 3'd0, 1'b0}, 8'h5a);                      // latch still taken
    bus_write({1'b1, 3'd0, 1'b1}, 8'h01);                      // push to count page ignored
    check_counts();

    @(negedge clk);
    $display("** PASS **");
    $finish;
  end

endmodule

// File: source/rdyq_bus_decode.sv
// bus cycle decoder: turns cs/vda/rw/ad into an access opcode, a queue index and the read wait state
`timescale 1ns/1ns

module rdyq_bus_decode (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             cs,
  input  logic                             vda,
  input  logic                             rw,      // 1 is read
  input  logic [rdyq_map_pkg::ADDR_W-1:0]  ad,
  output logic                             rdy,
  output logic                             fire,
  output rdyq_map_pkg::rdyq_op_e           op,
  output logic [rdyq_geom_pkg::QIDX_W-1:0] qidx
);
  import rdyq_map_pkg::*;
  import rdyq_geom_pkg::*;

  logic sel;                                        // valid cycle to this peripheral
  logic wait_q;                                     // read has spent its wait cycle

  assign sel = cs & vda;

  // ========================================
  // wait state
  // ========================================
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      wait_q <= 1'b0;
    else
      wait_q <= sel & rw;                           // clears in the idle gap
  end

  assign rdy  = (sel & rw) ? wait_q : 1'b1;         // writes never wait
  // only the completing cycle acts, so the wait cycle of a read cannot pop
  assign fire = sel & rdy;

  // ========================================
  // access classification
  // ========================================
  assign qidx = ad[QSEL_MSB:QSEL_LSB];

  always_comb
  begin
    if (!sel)
      op = op_none;
    else if (qidx >= QIDX_W'(NUM_QUEUES))
      op = op_unmapped;                             // indexes 5 to 7
    else if (!rw)
    begin
      if (ad[BYTE_SEL_BIT] == BYTE_LO)
        op = op_latch;
      else if (ad[REG_SEL_BIT] == REG_HEAD)
        op = op_push;
      else
        op = op_unmapped;                           // count page is read only
    end
    else if (ad[REG_SEL_BIT] == REG_COUNT)
      op = (ad[BYTE_SEL_BIT] == BYTE_HI) ? op_count_hi : op_count_lo;
    else
      op = (ad[BYTE_SEL_BIT] == BYTE_HI) ? op_peek_hi : op_pop_lo;
  end

endmodule

// File: source/rdyq_read_mux.sv
// read-data multiplexer: picks the bus byte from the queue heads and fill counts
`timescale 1ns/1ns

module rdyq_read_mux (
  input  rdyq_map_pkg::rdyq_op_e               op,
  input  logic [rdyq_geom_pkg::QIDX_W-1:0]     qidx,
  input  logic [rdyq_geom_pkg::HANDLE_W-1:0]   head_data [rdyq_geom_pkg::NUM_QUEUES],
  input  logic [rdyq_geom_pkg::NUM_QUEUES-1:0] head_valid,
  input  logic [rdyq_geom_pkg::COUNT_W-1:0]    count [rdyq_geom_pkg::NUM_QUEUES],
  output logic [rdyq_map_pkg::DATA_W-1:0]      o
);
  import rdyq_map_pkg::*;
  import rdyq_geom_pkg::*;

  logic [HANDLE_W-1:0] sel_head;                    // head of the indexed queue
  logic [COUNT_W-1:0]  sel_count;                   // its fill count

  // ========================================
  // queue select
  // ========================================
  always_comb
  begin
    sel_head  = '0;                                 // out-of-range index reads zero
    sel_count = '0;
    for (int q = 0; q < NUM_QUEUES; q++)
    begin
      if (qidx == QIDX_W'(q))
      begin
        sel_head  = head_valid[q] ? head_data[q] : '0;
        sel_count = count[q];
      end
    end
  end

  // ========================================
  // byte select
  // ========================================
  always_comb
  begin
    case (op)
      op_peek_hi:  o = {{(DATA_W-1){1'b0}}, sel_head[HANDLE_W-1]};
      op_pop_lo:   o = sel_head[DATA_W-1:0];
      op_count_lo: o = sel_count[DATA_W-1:0];
      op_count_hi: o = {{(DATA_W-1){1'b0}}, sel_count[COUNT_W-1]};
      default:     o = '0;                          // writes, idle, unmapped
    endcase
  end

endmodule
